// File: logic/offload_pkg.sv
// --------------------------------------------------------------------------
// Offload request and response types, tag and operand widths, unit address
// map and response source count
// --------------------------------------------------------------------------

package offload_pkg;

  localparam int data_w      = 32;
  localparam int tag_w       = 5;
  localparam int unit_addr_w = 2;
  localparam int op_w        = 2;

  // Unit address map
  localparam logic [unit_addr_w-1:0] unit_int    = 2'd0;
  localparam logic [unit_addr_w-1:0] unit_shared = 2'd1;
  // Addresses 2 and 3 stay unmapped

  // Integer unit, shared port and error slot
  localparam int resp_srcs = 3;

  typedef struct packed {
    logic [unit_addr_w-1:0] unit;
    logic [tag_w-1:0]       tag;
    logic [op_w-1:0]        op;
    logic [data_w-1:0]      arga;
    logic [data_w-1:0]      argb;
  } offload_req_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [tag_w-1:0]  tag;
    logic              error;
  } offload_resp_t;

endpackage

// File: logic/int_unit_pkg.sv
// --------------------------------------------------------------------------
// Integer unit operation codes and pipeline depth
// --------------------------------------------------------------------------

package int_unit_pkg;

  // Operation codes as carried in the request op field
  typedef enum logic [1:0] {
    op_add   = 2'd0,
    op_sub   = 2'd1,
    op_mul   = 2'd2,
    op_mulhu = 2'd3
  } int_op_e;

  // Register stages between request and response
  localparam int int_stages = 2;

endpackage

// File: logic/offload_spill_reg.sv
// --------------------------------------------------------------------------
// Two-entry spill register for any payload, with optional bypass
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module offload_spill_reg #(
  parameter type payload_t = logic,
  parameter bit  bypass    = 1'b0
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  if (bypass) begin : g_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : g_spill
    payload_t a_data_q, b_data_q;
    logic     a_full_q, b_full_q;
    logic     a_fill, a_drain, b_fill, b_drain;

    // Slot A takes new input, slot B holds the older item on a stall
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Ready while one entry is free
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
  end

endmodule

// File: logic/int_unit.sv
// --------------------------------------------------------------------------
// Two-stage integer unit: add, subtract, multiply, multiply-high unsigned
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module int_unit
  import offload_pkg::*;
  import int_unit_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic [tag_w-1:0]  req_tag_i,
  input  logic [op_w-1:0]   req_op_i,
  input  logic [data_w-1:0] req_arga_i,
  input  logic [data_w-1:0] req_argb_i,
  output logic              resp_valid_o,
  input  logic              resp_ready_i,
  output offload_resp_t     resp_o
);

  logic [int_stages-1:0] vld_q;
  logic                  advance;

  // Stage one
  int_op_e             op_q;
  logic [tag_w-1:0]    tag1_q;
  logic [data_w-1:0]   arga_q, argb_q;
  logic [data_w-1:0]   addsub;
  logic [2*data_w-1:0] prod;

  // Stage two
  logic [tag_w-1:0]  tag2_q;
  logic [data_w-1:0] res_d, res_q;

  // Whole pipeline moves together, holds while the output is stalled
  assign advance     = !vld_q[int_stages-1] || resp_ready_i;
  assign req_ready_o = advance;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      vld_q <= '0;
    end else if (advance) begin
      vld_q <= {vld_q[int_stages-2:0], req_valid_i};
    end
  end

  // --------------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (advance) begin
      op_q   <= int_op_e'(req_op_i);
      tag1_q <= req_tag_i;
      arga_q <= req_arga_i;
      argb_q <= req_argb_i;
      tag2_q <= tag1_q;
      res_q  <= res_d;
    end
  end

  assign addsub = (op_q == op_sub) ? arga_q - argb_q : arga_q + argb_q;
  // Full unsigned product
  assign prod   = {{data_w{1'b0}}, arga_q} * {{data_w{1'b0}}, argb_q};

  always_comb begin
    unique case (op_q)
      op_mul:   res_d = prod[data_w-1:0];
      op_mulhu: res_d = prod[2*data_w-1:data_w];
      default:  res_d = addsub;
    endcase
  end

  assign resp_valid_o = vld_q[int_stages-1];
  assign resp_o.data  = res_q;
  assign resp_o.tag   = tag2_q;
  assign resp_o.error = 1'b0;

endmodule

// File: logic/offload_router.sv
// --------------------------------------------------------------------------
// Request steering by unit address, error responder for unmapped units and
// round-robin response arbiter
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module offload_router
  import offload_pkg::*;
#(
  parameter type payload_t = offload_req_t
) (
  input  logic          clk_i,
  input  logic          rst_i,
  // Incoming request
  input  payload_t      req_i,
  input  logic          req_valid_i,
  output logic          req_ready_o,
  output logic          int_valid_o,
  input  logic          int_ready_i,
  output logic          sh_valid_o,
  input  logic          sh_ready_i,
  // Response sources
  input  offload_resp_t int_resp_i,
  input  logic          int_valid_i,
  output logic          int_ready_o,
  input  offload_resp_t sh_resp_i,
  input  logic          sh_valid_i,
  output logic          sh_ready_o,
  // Merged response
  output offload_resp_t resp_o,
  output logic          resp_valid_o,
  input  logic          resp_ready_i
);

  logic             is_int, is_sh, is_err;
  logic             err_valid_q;
  logic [tag_w-1:0] err_tag_q;
  offload_resp_t    err_resp;

  offload_resp_t        src_resp [resp_srcs];
  logic [resp_srcs-1:0] src_valid;
  logic [1:0]           rr_q, pick, win_idx, win_q;
  logic                 lock_q, resp_xfer;

  // --------------------------------------------------------------------------
  // Request steering
  // --------------------------------------------------------------------------
  assign is_int = (req_i.unit == unit_int);
  assign is_sh  = (req_i.unit == unit_shared);
  assign is_err = !is_int && !is_sh;

  assign int_valid_o = req_valid_i && is_int;
  assign sh_valid_o  = req_valid_i && is_sh;
  assign req_ready_o = is_int ? int_ready_i :
                       is_sh  ? sh_ready_i  : !err_valid_q;

  // One-entry error slot
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      err_valid_q <= 1'b0;
    end else if (req_valid_i && is_err && !err_valid_q) begin
      err_valid_q <= 1'b1;
    end else if (resp_xfer && win_idx == 2'd2) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && is_err && !err_valid_q) begin
      err_tag_q <= req_i.tag;
    end
  end

  assign err_resp.data  = '0;
  assign err_resp.tag   = err_tag_q;
  assign err_resp.error = 1'b1;

  // --------------------------------------------------------------------------
  // Response arbiter
  // --------------------------------------------------------------------------
  assign src_resp[0] = int_resp_i;
  assign src_resp[1] = sh_resp_i;
  assign src_resp[2] = err_resp;
  assign src_valid   = {err_valid_q, sh_valid_i, int_valid_i};

  // First valid source at or after the pointer
  always_comb begin
    int   idx;
    logic found;
    pick  = rr_q;
    found = 1'b0;
    for (int i = 0; i < resp_srcs; i++) begin
      idx = (int'(rr_q) + i) % resp_srcs;
      if (!found && src_valid[idx]) begin
        pick  = idx[1:0];
        found = 1'b1;
      end
    end
  end

  // Grant stays locked while the output is stalled
  assign win_idx      = lock_q ? win_q : pick;
  assign resp_valid_o = |src_valid;
  assign resp_o       = src_resp[win_idx];
  assign resp_xfer    = resp_valid_o && resp_ready_i;
  assign int_ready_o  = resp_ready_i && (win_idx == 2'd0);
  assign sh_ready_o   = resp_ready_i && (win_idx == 2'd1);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      win_q  <= '0;
    end else if (resp_xfer) begin
      rr_q   <= (win_idx == 2'(resp_srcs - 1)) ? 2'd0 : win_idx + 2'd1;
      lock_q <= 1'b0;
    end else if (resp_valid_o) begin
      lock_q <= 1'b1;
      win_q  <= win_idx;
    end
  end

endmodule

// File: logic/offload_top.sv
// --------------------------------------------------------------------------
// Offload complex top level with request and response spill registers,
// router and local integer unit
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module offload_top
  import offload_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Request port
  input  logic [unit_addr_w-1:0] req_unit_i,
  input  logic [tag_w-1:0]       req_tag_i,
  input  logic [op_w-1:0]        req_op_i,
  input  logic [data_w-1:0]      req_arga_i,
  input  logic [data_w-1:0]      req_argb_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  // Response port
  output logic [data_w-1:0]      resp_data_o,
  output logic [tag_w-1:0]       resp_tag_o,
  output logic                   resp_error_o,
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i,
  // Shared unit port
  output logic [tag_w-1:0]       sh_req_tag_o,
  output logic [op_w-1:0]        sh_req_op_o,
  output logic [data_w-1:0]      sh_req_arga_o,
  output logic [data_w-1:0]      sh_req_argb_o,
  output logic                   sh_req_valid_o,
  input  logic                   sh_req_ready_i,
  input  logic [data_w-1:0]      sh_resp_data_i,
  input  logic [tag_w-1:0]       sh_resp_tag_i,
  input  logic                   sh_resp_error_i,
  input  logic                   sh_resp_valid_i,
  output logic                   sh_resp_ready_o
);

  offload_req_t  req_d, req_q;
  logic          req_q_valid, req_q_ready;
  logic          int_req_valid, int_req_ready;
  offload_resp_t int_resp, sh_resp, arb_resp, resp_q;
  logic          int_resp_valid, int_resp_ready;
  logic          arb_valid, arb_ready;

  assign req_d.unit = req_unit_i;
  assign req_d.tag  = req_tag_i;
  assign req_d.op   = req_op_i;
  assign req_d.arga = req_arga_i;
  assign req_d.argb = req_argb_i;

  // Cut the request path
  offload_spill_reg #(
    .payload_t ( offload_req_t ),
    .bypass    ( 1'b0          )
  ) i_req_spill (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .valid_i ( req_valid_i ),
    .ready_o ( req_ready_o ),
    .data_i  ( req_d       ),
    .valid_o ( req_q_valid ),
    .ready_i ( req_q_ready ),
    .data_o  ( req_q       )
  );

  offload_router #(
    .payload_t ( offload_req_t )
  ) i_router (
    .clk_i        ( clk_i           ),
    .rst_i        ( rst_i           ),
    .req_i        ( req_q           ),
    .req_valid_i  ( req_q_valid     ),
    .req_ready_o  ( req_q_ready     ),
    .int_valid_o  ( int_req_valid   ),
    .int_ready_i  ( int_req_ready   ),
    .sh_valid_o   ( sh_req_valid_o  ),
    .sh_ready_i   ( sh_req_ready_i  ),
    .int_resp_i   ( int_resp        ),
    .int_valid_i  ( int_resp_valid  ),
    .int_ready_o  ( int_resp_ready  ),
    .sh_resp_i    ( sh_resp         ),
    .sh_valid_i   ( sh_resp_valid_i ),
    .sh_ready_o   ( sh_resp_ready_o ),
    .resp_o       ( arb_resp        ),
    .resp_valid_o ( arb_valid       ),
    .resp_ready_i ( arb_ready       )
  );

  int_unit i_int_unit (
    .clk_i        ( clk_i          ),
    .rst_i        ( rst_i          ),
    .req_valid_i  ( int_req_valid  ),
    .req_ready_o  ( int_req_ready  ),
    .req_tag_i    ( req_q.tag      ),
    .req_op_i     ( req_q.op       ),
    .req_arga_i   ( req_q.arga     ),
    .req_argb_i   ( req_q.argb     ),
    .resp_valid_o ( int_resp_valid ),
    .resp_ready_i ( int_resp_ready ),
    .resp_o       ( int_resp       )
  );

  // Shared unit gets the spilled request as is
  assign sh_req_tag_o  = req_q.tag;
  assign sh_req_op_o   = req_q.op;
  assign sh_req_arga_o = req_q.arga;
  assign sh_req_argb_o = req_q.argb;

  assign sh_resp.data  = sh_resp_data_i;
  assign sh_resp.tag   = sh_resp_tag_i;
  assign sh_resp.error = sh_resp_error_i;

  // Cut the response path
  offload_spill_reg #(
    .payload_t ( offload_resp_t ),
    .bypass    ( 1'b0           )
  ) i_resp_spill (
    .clk_i   ( clk_i        ),
    .rst_i   ( rst_i        ),
    .valid_i ( arb_valid    ),
    .ready_o ( arb_ready    ),
    .data_i  ( arb_resp     ),
    .valid_o ( resp_valid_o ),
    .ready_i ( resp_ready_i ),
    .data_o  ( resp_q       )
  );

  assign resp_data_o  = resp_q.data;
  assign resp_tag_o   = resp_q.tag;
  assign resp_error_o = resp_q.error;

endmodule

// File: testbench/offload_checker.sv
// --------------------------------------------------------------------------
// Handshake stability and reset assertions on the offload top-level ports
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module offload_checker
  import offload_pkg::*;
(
  input logic                           clk_i,
  input logic                           rst_i,
  input logic                           req_valid_i,
  input logic                           req_ready_i,
  input offload_req_t                   req_data_i,
  input logic                           resp_valid_i,
  input logic                           resp_ready_i,
  input offload_resp_t                  resp_data_i,
  input logic                           sh_valid_i,
  input logic                           sh_ready_i,
  input logic [tag_w+op_w+2*data_w-1:0] sh_data_i,
  input logic [2:0]                     inner_valid_i
);

  // Count of failed assertions, polled by the testbench
  int fail_cnt = 0;

  // Valid and payload hold until the handshake
  req_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_data_i))
    else begin
      $error("request valid or payload changed before its handshake");
      fail_cnt++;
    end

  resp_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_data_i))
    else begin
      $error("response valid or payload changed before its handshake");
      fail_cnt++;
    end

  sh_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    sh_valid_i && !sh_ready_i |=> sh_valid_i && $stable(sh_data_i))
    else begin
      $error("shared request valid or payload changed before its handshake");
      fail_cnt++;
    end

  // Nothing valid while reset is applied
  rst_quiet_a: assert property (@(posedge clk_i)
    rst_i |-> !req_valid_i && !resp_valid_i && !sh_valid_i && (inner_valid_i == '0))
    else begin
      $error("a valid signal is high during reset");
      fail_cnt++;
    end

endmodule

// File: testbench/offload_tb.sv
// --------------------------------------------------------------------------
// Offload complex testbench with stimulus table, shared unit model,
// scoreboard and watchdog
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module offload_tb
  import offload_pkg::*;
  import int_unit_pkg::*;
();

  typedef struct packed {
    logic [unit_addr_w-1:0] unit;
    int_op_e                op;
    logic [data_w-1:0]      a;
    logic [data_w-1:0]      b;
  } row_t;

  typedef struct packed {
    logic [tag_w-1:0]  tag;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
  } sh_item_t;

  logic                   clk_i           = 1'b0;
  logic                   rst_i           = 1'b0;
  logic [unit_addr_w-1:0] req_unit_i      = '0;
  logic [tag_w-1:0]       req_tag_i       = '0;
  logic [op_w-1:0]        req_op_i        = '0;
  logic [data_w-1:0]      req_arga_i      = '0;
  logic [data_w-1:0]      req_argb_i      = '0;
  logic                   req_valid_i     = 1'b0;
  logic                   resp_ready_i    = 1'b0;
  logic                   sh_req_ready_i  = 1'b0;
  logic [data_w-1:0]      sh_resp_data_i  = '0;
  logic [tag_w-1:0]       sh_resp_tag_i   = '0;
  logic                   sh_resp_error_i = 1'b0;
  logic                   sh_resp_valid_i = 1'b0;
  logic                   req_ready_o, resp_error_o, resp_valid_o;
  logic                   sh_req_valid_o, sh_resp_ready_o;
  logic [data_w-1:0]      resp_data_o, sh_req_arga_o, sh_req_argb_o;
  logic [tag_w-1:0]       resp_tag_o, sh_req_tag_o;
  logic [op_w-1:0]        sh_req_op_o;

  // Stimulus table, expected response per tag and shared unit queue
  row_t              rows [$];
  logic [data_w-1:0] exp_data [1 << tag_w];
  logic              exp_err  [1 << tag_w];
  logic              exp_sent [1 << tag_w] = '{default: 1'b0};
  logic              seen     [1 << tag_w] = '{default: 1'b0};
  sh_item_t          sh_q [$];
  int                sh_delay = 0;
  int                done_cnt = 0;
  int                seed     = 58917;

  offload_top DUT (.*);

  bind offload_top offload_checker i_checker (
    .clk_i         ( clk_i                                                  ),
    .rst_i         ( rst_i                                                  ),
    .req_valid_i   ( req_valid_i                                            ),
    .req_ready_i   ( req_ready_o                                            ),
    .req_data_i    ( req_d                                                  ),
    .resp_valid_i  ( resp_valid_o                                           ),
    .resp_ready_i  ( resp_ready_i                                           ),
    .resp_data_i   ( resp_q                                                 ),
    .sh_valid_i    ( sh_req_valid_o                                         ),
    .sh_ready_i    ( sh_req_ready_i                                         ),
    .sh_data_i     ( {sh_req_tag_o, sh_req_op_o, sh_req_arga_o, sh_req_argb_o} ),
    .inner_valid_i ( {req_q_valid, int_resp_valid, arb_valid}               )
  );

  always #4 clk_i = ~clk_i;

  task automatic add_row(input logic [unit_addr_w-1:0] unit, input int_op_e op,
                         input logic [data_w-1:0] a, input logic [data_w-1:0] b);
    row_t r;
    r = '{unit, op, a, b};
    rows.push_back(r);
  endtask

  task automatic abort_run(input string reason);
    $display("ERROR: %s", reason);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [data_w-1:0] expected,
                               input logic [data_w-1:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  // Error flag and data word for one row, from the unit rules
  function automatic logic [data_w:0] model_result(input row_t r);
    logic [2*data_w-1:0] prod;
    prod = 64'(r.a) * 64'(r.b);
    if (r.unit == unit_shared) return {1'b0, r.a ^ r.b};
    if (r.unit != unit_int) return {1'b1, {data_w{1'b0}}};
    case (r.op)
      op_add:  return {1'b0, r.a + r.b};
      op_sub:  return {1'b0, r.a - r.b};
      op_mul:  return {1'b0, prod[data_w-1:0]};
      default: return {1'b0, prod[2*data_w-1:data_w]};
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    // Integer unit, overflow and all-ones cases first
    add_row(2'd0, op_add,   32'hffff_ffff, 32'h0000_0001);
    add_row(2'd0, op_add,   32'h1234_5678, 32'h0edc_ba98);
    add_row(2'd0, op_sub,   32'h0000_0003, 32'h0000_0005);
    add_row(2'd0, op_sub,   32'h8000_0000, 32'h0000_0001);
    add_row(2'd0, op_mul,   32'h0001_0000, 32'h0001_0000);
    add_row(2'd0, op_mul,   32'hffff_ffff, 32'hffff_ffff);
    add_row(2'd0, op_mulhu, 32'hffff_ffff, 32'hffff_ffff);
    add_row(2'd0, op_mulhu, 32'h8000_0000, 32'h0000_0004);
    // Mixed units back to back
    add_row(2'd1, op_add,   32'hdead_beef, 32'h0f0f_0f0f);
    add_row(2'd1, op_mulhu, 32'hffff_ffff, 32'h0000_0000);
    add_row(2'd2, op_add,   32'h1111_1111, 32'h2222_2222);
    add_row(2'd3, op_mul,   32'ha5a5_a5a5, 32'h5a5a_5a5a);
    add_row(2'd1, op_sub,   32'h1357_9bdf, 32'h2468_ace0);
    add_row(2'd0, op_mul,   32'h1234_5678, 32'h9abc_def0);
    add_row(2'd3, op_sub,   32'h0000_0000, 32'h0000_0000);
    add_row(2'd1, op_add,   32'hcafe_f00d, 32'h1234_5678);
    rst_i = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    for (int i = 0; i < rows.size(); i++) begin
      {exp_err[i], exp_data[i]} = model_result(rows[i]);
      exp_sent[i] = 1'b1;
      req_unit_i  <= rows[i].unit;
      req_tag_i   <= tag_w'(i);
      req_op_i    <= rows[i].op;
      req_arga_i  <= rows[i].a;
      req_argb_i  <= rows[i].b;
      req_valid_i <= 1'b1;
      @(posedge clk_i);
      while (!req_ready_o) @(posedge clk_i);
    end
    req_valid_i <= 1'b0;
    while (done_cnt < rows.size()) @(posedge clk_i);
    // Port must stay quiet once drained
    repeat (20) begin
      @(posedge clk_i);
      if (resp_valid_o) abort_run("response valid high after all tags completed");
    end
    // Assertions of the last edge settle before the verdict
    @(negedge clk_i);
    if (DUT.i_checker.fail_cnt != 0) begin
      abort_run("a handshake assertion on the top-level ports failed");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Shared unit model and random back-pressure
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin : sh_model
    sh_item_t         item;
    logic [tag_w-1:0] t;
    t = sh_req_tag_o;
    if (!rst_i) begin
      resp_ready_i   <= ($random(seed) & 3) != 0;
      sh_req_ready_i <= ($random(seed) & 1) != 0;
      if (sh_req_valid_o && sh_req_ready_i) begin
        if (int'(t) >= rows.size()) begin
          abort_run($sformatf("shared port got unknown tag %0d", t));
        end else if (rows[t].unit != unit_shared) begin
          abort_run($sformatf("row %0d reached the shared port", t));
        end else begin
          compare_value($sformatf("row %0d shared op", t), 32'(rows[t].op), 32'(sh_req_op_o));
          compare_value($sformatf("row %0d shared A", t), rows[t].a, sh_req_arga_o);
          compare_value($sformatf("row %0d shared B", t), rows[t].b, sh_req_argb_o);
          sh_q.push_back({t, sh_req_arga_o, sh_req_argb_o});
        end
      end
      if (sh_resp_valid_i && sh_resp_ready_o) begin
        sh_resp_valid_i <= 1'b0;
      end else if (!sh_resp_valid_i && sh_q.size() != 0) begin
        if (sh_delay != 0) begin
          sh_delay <= sh_delay - 1;
        end else begin
          item = sh_q.pop_front();
          sh_resp_data_i  <= item.a ^ item.b;
          sh_resp_tag_i   <= item.tag;
          sh_resp_error_i <= 1'b0;
          sh_resp_valid_i <= 1'b1;
          sh_delay        <= $random(seed) & 7;
        end
      end
    end
  end

  // Scoreboard, one response per tag
  always @(posedge clk_i) begin : scoreboard
    logic [tag_w-1:0] t;
    t = resp_tag_o;
    if (DUT.i_checker.fail_cnt != 0) begin
      abort_run("a handshake assertion on the top-level ports failed");
    end else if (!rst_i && resp_valid_o && resp_ready_i) begin
      if (!exp_sent[t]) begin
        abort_run($sformatf("response with tag %0d that was never sent", t));
      end else if (seen[t]) begin
        abort_run($sformatf("tag %0d answered more than once", t));
      end else begin
        compare_value($sformatf("row %0d data", t), exp_data[t], resp_data_o);
        compare_value($sformatf("row %0d error", t), 32'(exp_err[t]), 32'(resp_error_o));
        seen[t]  <= 1'b1;
        done_cnt <= done_cnt + 1;
      end
    end
  end

  // Watchdog, 50 cycles per table row
  initial begin
    @(negedge rst_i);
    repeat (rows.size() * 50) @(posedge clk_i);
    $display("ERROR: timeout with %0d of %0d responses received", done_cnt, rows.size());
    $display("*** FAILED ***");
    $fatal(1);
  end

endmodule

// File: all.f
logic/offload_pkg.sv
logic/int_unit_pkg.sv
logic/offload_spill_reg.sv
logic/int_unit.sv
logic/offload_router.sv
logic/offload_top.sv
testbench/offload_checker.sv
testbench/offload_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= offload_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
